// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b  // Operand B straight through.
    } alu_op_t;

    // Source of ALU operand A.
    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero
    } a_sel_t;

    // Source of the writeback value.
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_t;

endpackage

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire logic [rv_pkg::XLEN-1:0] instr,
    output logic                         reg_write,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic                         branch,
    output logic                         jump,
    output logic                         alu_src,
    output rv_pkg::a_sel_t               a_sel,
    output rv_pkg::wb_sel_t              wb_sel,
    output rv_pkg::alu_op_t              alu_op,
    output logic                         uses_rs1,
    output logic                         uses_rs2
);

    logic [2:0]      funct3;
    logic            is_reg_op;
    rv_pkg::alu_op_t arith_op;

    assign funct3    = instr[14:12];
    assign is_reg_op = (instr[6:0] == rv_pkg::opc_op);

    // Bit 30 picks sub only for register ops; for shifts it picks sra in both forms.
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg_op && instr[30]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = instr[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            3'b111:  arith_op = rv_pkg::alu_and;
            default: arith_op = rv_pkg::alu_add;
        endcase
    end

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        alu_src   = 1'b0;
        a_sel     = rv_pkg::a_rs1;
        wb_sel    = rv_pkg::wb_alu;
        alu_op    = rv_pkg::alu_add;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (instr[6:0])
            rv_pkg::opc_op: begin
                reg_write = 1'b1;
                alu_op    = arith_op;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = arith_op;
                uses_rs1  = 1'b1;
            end
            rv_pkg::opc_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
                wb_sel    = rv_pkg::wb_mem;
                uses_rs1  = 1'b1;
            end
            rv_pkg::opc_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            rv_pkg::opc_branch: begin
                branch    = 1'b1;
                alu_op    = rv_pkg::alu_sub;  // Compare through zero flag.
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            rv_pkg::opc_jal: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = rv_pkg::wb_pc4;
            end
            rv_pkg::opc_lui: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                a_sel     = rv_pkg::a_zero;
                alu_op    = rv_pkg::alu_pass_b;
            end
            rv_pkg::opc_auipc: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                a_sel     = rv_pkg::a_pc;
            end
            default: ;  // Unknown opcode behaves as a bubble.
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  wire logic [rv_pkg::XLEN-1:0] instr,
    output logic      [rv_pkg::XLEN-1:0] imm
);

    always_comb begin
        case (instr[6:0])
            rv_pkg::opc_op_imm,
            rv_pkg::opc_load:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::opc_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::opc_branch:  // Scrambled B format.
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::opc_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                       1'b0};
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc:
                imm = {instr[31:12], 12'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire logic [rv_pkg::XLEN-1:0] a,
    input  wire logic [rv_pkg::XLEN-1:0] b,
    input  wire rv_pkg::alu_op_t         op,
    output logic      [rv_pkg::XLEN-1:0] result,
    output logic                         zero
);

    always_comb begin
        case (op)
            rv_pkg::alu_add:    result = a + b;
            rv_pkg::alu_sub:    result = a - b;
            rv_pkg::alu_and:    result = a & b;
            rv_pkg::alu_or:     result = a | b;
            rv_pkg::alu_xor:    result = a ^ b;
            rv_pkg::alu_slt:    result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::alu_sll:    result = a << b[4:0];
            rv_pkg::alu_srl:    result = a >> b[4:0];
            rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> b[4:0]);
            rv_pkg::alu_pass_b: result = b;
            default:            result = '0;
        endcase
    end

    assign zero = (result == '0);  // Used by beq and bne.

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic                    CLK,
    input  wire logic                    RESET_N,
    input  wire logic [4:0]              rs1,
    input  wire logic [4:0]              rs2,
    input  wire logic [4:0]              rd,
    input  wire logic [rv_pkg::XLEN-1:0] write_data,
    input  wire logic                    write_enable,
    output logic      [rv_pkg::XLEN-1:0] rs1_data,
    output logic      [rv_pkg::XLEN-1:0] rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage.

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    // Same-cycle write is passed through to the readers.
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (write_enable && rd == rs1) ? write_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (write_enable && rd == rs2) ? write_data : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
    input  wire logic [4:0] id_rs1,
    input  wire logic [4:0] id_rs2,
    input  wire logic       id_uses_rs1,
    input  wire logic       id_uses_rs2,
    input  wire logic [4:0] ex_rd,
    input  wire logic       ex_reg_write,
    input  wire logic [4:0] mem_rd,
    input  wire logic       mem_reg_write,
    output logic            stall
);

    logic rs1_busy;
    logic rs2_busy;

    // Writeback needs no check, the register file passes it through.
    assign rs1_busy = id_uses_rs1 && id_rs1 != 5'd0 &&
                      ((ex_reg_write && ex_rd == id_rs1) || (mem_reg_write && mem_rd == id_rs1));
    assign rs2_busy = id_uses_rs2 && id_rs2 != 5'd0 &&
                      ((ex_reg_write && ex_rd == id_rs2) || (mem_reg_write && mem_rd == id_rs2));
    assign stall    = rs1_busy || rs2_busy;

endmodule

`default_nettype wire

// File: hdl/rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline #(
    parameter int ADDR_SIZE = 10
) (
    input  wire logic                    CLK,
    input  wire logic                    RESET_N,
    input  wire logic                    clear,
    input  wire logic [rv_pkg::XLEN-1:0] idata,
    output logic      [ADDR_SIZE-1:0]    iaddr,
    output logic      [ADDR_SIZE-1:0]    daddr,
    input  wire logic [rv_pkg::XLEN-1:0] ddata_r,
    output logic      [rv_pkg::XLEN-1:0] ddata_w,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic      [rv_pkg::XLEN-1:0] reg_write_data,
    output logic                         reg_write_enable,
    output logic      [4:0]              write_register
);

    localparam int PC_W = ADDR_SIZE + 2;

    logic [PC_W-1:0] pc, pc_plus4;
    logic            stall, taken;

    logic [rv_pkg::XLEN-1:0] id_instr, id_imm, id_rs1_data, id_rs2_data;
    logic [PC_W-1:0]         id_pc, id_pc4;
    logic                    id_reg_write, id_load, id_store, id_branch, id_jump, id_alu_src;
    logic                    id_uses_rs1, id_uses_rs2;
    rv_pkg::a_sel_t          id_a_sel;
    rv_pkg::wb_sel_t         id_wb_sel;
    rv_pkg::alu_op_t         id_alu_op;

    logic                    ex_reg_write, ex_load, ex_store, ex_branch, ex_jump;
    logic                    ex_alu_src, ex_branch_ne, ex_zero;
    rv_pkg::a_sel_t          ex_a_sel;
    rv_pkg::wb_sel_t         ex_wb_sel;
    rv_pkg::alu_op_t         ex_alu_op;
    logic [4:0]              ex_rd;
    logic [PC_W-1:0]         ex_pc, ex_pc4, ex_target;
    logic [rv_pkg::XLEN-1:0] ex_rs1_data, ex_rs2_data, ex_imm, alu_a, alu_b, ex_result;

    logic                    mem_reg_write, mem_load, mem_store, mem_branch, mem_jump;
    logic                    mem_branch_ne, mem_zero;
    rv_pkg::wb_sel_t         mem_wb_sel;
    logic [4:0]              mem_rd;
    logic [PC_W-1:0]         mem_target, mem_pc4;
    logic [rv_pkg::XLEN-1:0] mem_result, mem_rs2_data;

    logic                    wb_reg_write;
    rv_pkg::wb_sel_t         wb_sel;
    logic [4:0]              wb_rd;
    logic [PC_W-1:0]         wb_pc4;
    logic [rv_pkg::XLEN-1:0] wb_result, wb_mem_data, wb_value;

    // Fetch.
    assign pc_plus4 = pc + PC_W'(4);
    assign iaddr    = pc[PC_W-1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (taken) begin
            pc <= mem_target;  // Redirect wins over a stall.
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    // IF/ID. An all-zero word decodes as a bubble.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_instr <= '0;
        end else if (clear || taken) begin
            id_instr <= '0;
        end else if (!stall) begin
            id_instr <= idata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            id_pc  <= pc;
            id_pc4 <= pc_plus4;
        end
    end

    // Decode.
    rv_decoder i_decoder (
        .instr(id_instr), .reg_write(id_reg_write), .mem_read(id_load),
        .mem_write(id_store), .branch(id_branch), .jump(id_jump), .alu_src(id_alu_src),
        .a_sel(id_a_sel), .wb_sel(id_wb_sel), .alu_op(id_alu_op),
        .uses_rs1(id_uses_rs1), .uses_rs2(id_uses_rs2)
    );

    rv_imm_gen i_imm_gen (.instr(id_instr), .imm(id_imm));

    rv_regfile i_regfile (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(id_instr[19:15]), .rs2(id_instr[24:20]),
        .rd(wb_rd), .write_data(wb_value), .write_enable(wb_reg_write),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
    );

    rv_hazard_unit i_hazard_unit (
        .id_rs1(id_instr[19:15]), .id_rs2(id_instr[24:20]),
        .id_uses_rs1(id_uses_rs1), .id_uses_rs2(id_uses_rs2),
        .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .stall(stall)
    );

    // ID/EX. A stall leaves a bubble behind the held instruction.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            {ex_reg_write, ex_load, ex_store, ex_branch, ex_jump} <= '0;
        end else if (clear || taken || stall) begin
            {ex_reg_write, ex_load, ex_store, ex_branch, ex_jump} <= '0;
        end else begin
            {ex_reg_write, ex_load, ex_store, ex_branch, ex_jump} <=
                {id_reg_write, id_load, id_store, id_branch, id_jump};
        end
    end

    always_ff @(posedge CLK) begin
        ex_alu_src   <= id_alu_src;
        ex_a_sel     <= id_a_sel;
        ex_wb_sel    <= id_wb_sel;
        ex_alu_op    <= id_alu_op;
        ex_branch_ne <= id_instr[12];  // funct3 bit 0 tells bne from beq.
        ex_rd        <= id_instr[11:7];
        ex_pc        <= id_pc;
        ex_pc4       <= id_pc4;
        ex_rs1_data  <= id_rs1_data;
        ex_rs2_data  <= id_rs2_data;
        ex_imm       <= id_imm;
    end

    // Execute.
    always_comb begin
        case (ex_a_sel)
            rv_pkg::a_pc:   alu_a = {{(rv_pkg::XLEN-PC_W){1'b0}}, ex_pc};
            rv_pkg::a_zero: alu_a = '0;
            default:        alu_a = ex_rs1_data;
        endcase
    end

    assign alu_b     = ex_alu_src ? ex_imm : ex_rs2_data;
    assign ex_target = ex_pc + ex_imm[PC_W-1:0];

    rv_alu i_alu (.a(alu_a), .b(alu_b), .op(ex_alu_op), .result(ex_result), .zero(ex_zero));

    // EX/MEM.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            {mem_reg_write, mem_load, mem_store, mem_branch, mem_jump} <= '0;
        end else if (clear || taken) begin
            {mem_reg_write, mem_load, mem_store, mem_branch, mem_jump} <= '0;
        end else begin
            {mem_reg_write, mem_load, mem_store, mem_branch, mem_jump} <=
                {ex_reg_write, ex_load, ex_store, ex_branch, ex_jump};
        end
    end

    always_ff @(posedge CLK) begin
        mem_branch_ne <= ex_branch_ne;
        mem_zero      <= ex_zero;
        mem_wb_sel    <= ex_wb_sel;
        mem_rd        <= ex_rd;
        mem_target    <= ex_target;
        mem_pc4       <= ex_pc4;
        mem_result    <= ex_result;
        mem_rs2_data  <= ex_rs2_data;
    end

    // Memory stage and branch resolution.
    assign taken     = mem_jump || (mem_branch && (mem_branch_ne ? !mem_zero : mem_zero));
    assign daddr     = mem_result[PC_W-1:2];
    assign ddata_w   = mem_rs2_data;
    assign mem_read  = mem_load;
    assign mem_write = mem_store;

    // MEM/WB.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wb_reg_write <= 1'b0;
        end else if (clear) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= mem_reg_write;
        end
    end

    always_ff @(posedge CLK) begin
        wb_sel      <= mem_wb_sel;
        wb_rd       <= mem_rd;
        wb_pc4      <= mem_pc4;
        wb_result   <= mem_result;
        wb_mem_data <= ddata_r;
    end

    // Writeback.
    always_comb begin
        case (wb_sel)
            rv_pkg::wb_mem: wb_value = wb_mem_data;
            rv_pkg::wb_pc4: wb_value = {{(rv_pkg::XLEN-PC_W){1'b0}}, wb_pc4};
            default:        wb_value = wb_result;
        endcase
    end

    assign reg_write_data   = wb_value;
    assign reg_write_enable = wb_reg_write;
    assign write_register   = wb_rd;

endmodule

`default_nettype wire

// File: testbench/tb_rv_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_memory #(
    parameter int ADDR_SIZE = 10
) (
    input  wire logic                 CLK,
    input  wire logic [ADDR_SIZE-1:0] iaddr,
    output logic      [31:0]          idata,
    input  wire logic [ADDR_SIZE-1:0] daddr,
    input  wire logic [31:0]          ddata_w,
    input  wire logic                 mem_write,
    output logic      [31:0]          ddata_r
);

    logic [31:0] rom [0:(1 << ADDR_SIZE)-1];
    logic [31:0] ram [0:(1 << ADDR_SIZE)-1];

    initial begin
        for (int a = 0; a < (1 << ADDR_SIZE); a++) begin
            rom[a] = '0;                    // Decodes as a bubble.
            ram[a] = {~a[15:0], a[15:0]};
        end
    end

    // Both ports read in the same cycle.
    assign idata   = rom[iaddr];
    assign ddata_r = ram[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            ram[daddr] <= ddata_w;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipeline;

    localparam int ADDR_SIZE   = 10;
    localparam int CLEAR_AT    = 6;     // Entries seen before the mid-program clear.
    localparam int CYCLE_LIMIT = 1000;  // Two runs of ~40 instructions at 4 cycles with margin.
    localparam int EV_WB       = 0;
    localparam int EV_LOAD     = 1;
    localparam int EV_STORE    = 2;

    logic                 CLK;
    logic                 RESET_N;
    logic                 clear;
    logic [31:0]          idata;
    logic [ADDR_SIZE-1:0] iaddr;
    logic [ADDR_SIZE-1:0] daddr;
    logic [31:0]          ddata_r;
    logic [31:0]          ddata_w;
    logic                 mem_read;
    logic                 mem_write;
    logic [31:0]          reg_write_data;
    logic                 reg_write_enable;
    logic [4:0]           write_register;

    int          ev_kind [0:63];
    int          ev_beh [0:63];
    logic [31:0] ev_key [0:63];
    logic [31:0] ev_value [0:63];
    int          beh_last [1:6];
    int          beh_errors [1:6];
    int          n_events;
    int          idx;
    int          pass;
    int          cycles;
    int          checks_passed;
    int          checks_failed;
    logic        restart_now;
    logic        fetch_check;
    logic        finished;

    rv_pipeline #(.ADDR_SIZE(ADDR_SIZE)) i_dut (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear), .idata(idata), .iaddr(iaddr),
        .daddr(daddr), .ddata_r(ddata_r), .ddata_w(ddata_w), .mem_read(mem_read),
        .mem_write(mem_write), .reg_write_data(reg_write_data),
        .reg_write_enable(reg_write_enable), .write_register(write_register)
    );

    tb_rv_memory #(.ADDR_SIZE(ADDR_SIZE)) i_mem (
        .CLK(CLK), .iaddr(iaddr), .idata(idata), .daddr(daddr), .ddata_w(ddata_w),
        .mem_write(mem_write), .ddata_r(ddata_r)
    );

    task automatic load_program;
        i_mem.rom[0]  = 32'h123450b7;  // lui   x1, 0x12345
        i_mem.rom[1]  = 32'h06400113;  // addi  x2, x0, 100
        i_mem.rom[2]  = 32'hff900193;  // addi  x3, x0, -7
        i_mem.rom[3]  = 32'h00001217;  // auipc x4, 1
        i_mem.rom[4]  = 32'h403102b3;  // sub   x5, x2, x3
        i_mem.rom[5]  = 32'h0030c333;  // xor   x6, x1, x3
        i_mem.rom[6]  = 32'h003163b3;  // or    x7, x2, x3
        i_mem.rom[7]  = 32'h00317433;  // and   x8, x2, x3
        i_mem.rom[8]  = 32'h0021a4b3;  // slt   x9, x3, x2
        i_mem.rom[9]  = 32'h00411513;  // slli  x10, x2, 4
        i_mem.rom[10] = 32'h01c1d593;  // srli  x11, x3, 28
        i_mem.rom[11] = 32'h4091d633;  // sra   x12, x3, x9
        i_mem.rom[12] = 32'h0ff14693;  // xori  x13, x2, 0xff
        i_mem.rom[13] = 32'h06312713;  // slti  x14, x2, 99
        i_mem.rom[14] = 32'h002107b3;  // add   x15, x2, x2
        i_mem.rom[15] = 32'h00f78833;  // add   x16, x15, x15
        i_mem.rom[16] = 32'hfff80893;  // addi  x17, x16, -1
        i_mem.rom[17] = 32'h05102023;  // sw    x17, 64(x0)
        i_mem.rom[18] = 32'h04002903;  // lw    x18, 64(x0)
        i_mem.rom[19] = 32'h002909b3;  // add   x19, x18, x2
        i_mem.rom[20] = 32'h03700013;  // addi  x0, x0, 55
        i_mem.rom[21] = 32'h00d00a33;  // add   x20, x0, x13
        i_mem.rom[22] = 32'h00210663;  // beq   x2, x2, +12
        i_mem.rom[23] = 32'h00100a93;  // addi  x21, x0, 1   (squashed)
        i_mem.rom[24] = 32'h05502223;  // sw    x21, 68(x0)  (squashed)
        i_mem.rom[25] = 32'h00211463;  // bne   x2, x2, +8
        i_mem.rom[26] = 32'h00c00b6f;  // jal   x22, +12
        i_mem.rom[27] = 32'h00200b93;  // addi  x23, x0, 2   (squashed)
        i_mem.rom[28] = 32'h00300c13;  // addi  x24, x0, 3   (squashed)
        i_mem.rom[29] = 32'h001b0c93;  // addi  x25, x22, 1
        i_mem.rom[30] = 32'h5a500f93;  // addi  x31, x0, 0x5a5  (end marker)
    endtask

    task automatic add_event(input int kind, input int beh, input logic [31:0] key,
                             input logic [31:0] value);
        ev_kind[n_events]  = kind;
        ev_beh[n_events]   = beh;
        ev_key[n_events]   = key;
        ev_value[n_events] = value;
        beh_last[beh]      = n_events;
        n_events++;
    endtask

    // Program order. Register writes give (rd, value) and memory strobes give (word address, data).
    task automatic build_expectations;
        add_event(EV_WB, 1, 1, 32'h12345000);
        add_event(EV_WB, 1, 2, 32'h00000064);
        add_event(EV_WB, 1, 3, 32'hfffffff9);
        add_event(EV_WB, 1, 4, 32'h0000100c);
        add_event(EV_WB, 1, 5, 32'h0000006b);
        add_event(EV_WB, 1, 6, 32'hedcbaff9);
        add_event(EV_WB, 1, 7, 32'hfffffffd);
        add_event(EV_WB, 1, 8, 32'h00000060);
        add_event(EV_WB, 1, 9, 32'h00000001);
        add_event(EV_WB, 1, 10, 32'h00000640);
        add_event(EV_WB, 1, 11, 32'h0000000f);
        add_event(EV_WB, 1, 12, 32'hfffffffc);
        add_event(EV_WB, 1, 13, 32'h0000009b);
        add_event(EV_WB, 1, 14, 32'h00000000);
        add_event(EV_WB, 2, 15, 32'h000000c8);
        add_event(EV_WB, 2, 16, 32'h00000190);
        add_event(EV_WB, 2, 17, 32'h0000018f);
        add_event(EV_STORE, 3, 32'h10, 32'h0000018f);
        add_event(EV_LOAD, 3, 32'h10, 32'h0);
        add_event(EV_WB, 3, 18, 32'h0000018f);
        add_event(EV_WB, 2, 19, 32'h000001f3);
        add_event(EV_WB, 5, 0, 32'h00000037);   // Strobe is visible but the register is not.
        add_event(EV_WB, 5, 20, 32'h0000009b);
        add_event(EV_WB, 4, 22, 32'h0000006c);  // Link is jal address plus four.
        add_event(EV_WB, 4, 25, 32'h0000006d);
        add_event(EV_WB, 4, 31, 32'h000005a5);
    endtask

    function automatic string describe_behavior(input int beh);
        case (beh)
            1:       return "ALU, lui and auipc results";
            2:       return "dependent instructions and load use";
            3:       return "store then load";
            4:       return "branches, jal and squashing";
            5:       return "writes to x0";
            default: return "restart by clear";
        endcase
    endfunction

    task automatic report_behavior(input int beh);
        $display("behavior %0d, %s: %0d errors", beh, describe_behavior(beh), beh_errors[beh]);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want, input int beh);
        assert (got === want) begin
            checks_passed++;
        end else begin
            checks_failed++;
            beh_errors[beh]++;
            $display("FAILED at %t: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
        end
    endtask

    task automatic check_event(input int kind, input string what, input logic [31:0] key,
                               input logic [31:0] value, input string key_name,
                               input string value_name);
        logic match;
        int   beh;
        match = (idx < n_events) && (ev_kind[idx] == kind);
        assert (match) else begin
            checks_failed++;
            if (idx < n_events) begin
                beh_errors[ev_beh[idx]]++;
            end
            $display("Unexpected %s at %t, the table expects a different event next.",
                     what, $time);
        end
        if (match) begin
            beh = ev_beh[idx];
            check_value(key_name, key, ev_key[idx], beh);
            if (kind != EV_LOAD) begin
                check_value(value_name, value, ev_value[idx], beh);
            end
            if (pass == 1 && idx == beh_last[beh]) begin
                report_behavior(beh);
            end
            idx++;
        end
    endtask

    // Writeback holds the older instruction, so it goes first.
    task automatic check_cycle;
        if (reg_write_enable) begin
            check_event(EV_WB, "register write", 32'(write_register), reg_write_data,
                        "write_register", "reg_write_data");
        end
        if (mem_read) begin
            check_event(EV_LOAD, "load", 32'(daddr), ddata_r, "daddr", "ddata_r");
        end
        if (mem_write) begin
            check_event(EV_STORE, "store", 32'(daddr), ddata_w, "daddr", "ddata_w");
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        RESET_N       = 1'b0;
        clear         = 1'b0;
        n_events      = 0;
        idx           = 0;
        pass          = 0;
        cycles        = 0;
        checks_passed = 0;
        checks_failed = 0;
        restart_now   = 1'b0;
        fetch_check   = 1'b1;
        finished      = 1'b0;
        for (int b = 1; b <= 6; b++) begin
            beh_last[b]   = 0;
            beh_errors[b] = 0;
        end
        $timeformat(-9, 0, " ns", 0);
        build_expectations();
        @(posedge CLK);
        load_program();
        repeat (2) @(posedge CLK);
        #1 RESET_N = 1'b1;

        while (!finished && cycles < CYCLE_LIMIT) begin
            @(negedge CLK);
            cycles++;
            if (fetch_check) begin
                // Fetch restarts at address zero.
                check_value("iaddr", 32'(iaddr), 32'h0, (pass == 0) ? 1 : 6);
                fetch_check = 1'b0;
            end
            check_cycle();
            if (clear) begin
                idx         = 0;  // Clear takes effect at the next edge.
                pass        = 1;
                restart_now = 1'b0;
                fetch_check = 1'b1;
            end else if (pass == 0 && idx >= CLEAR_AT) begin
                restart_now = 1'b1;
            end
            if (pass == 1 && idx == n_events) begin
                finished      = 1'b1;
                beh_errors[6] = checks_failed;
                report_behavior(6);
            end
            @(posedge CLK);
            #1;
            clear = restart_now;
        end

        if (!finished) begin
            $display("Timeout: the program did not reach its last writeback within %0d cycles.",
                     CYCLE_LIMIT);
        end
        $display("checks passed: %0d, checks failed: %0d", checks_passed, checks_failed);
        if (finished && checks_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_imm_gen.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_hazard_unit.sv
hdl/rv_pipeline.sv
testbench/tb_rv_memory.sv
testbench/tb_rv_pipeline.sv
